// ==== verilog.f ====
frontend_pkg.sv
fetch_req_ctrl.sv
bus_tracker.sv
prefetch_fifo.sv
instr_assembler.sv
frontend_top.sv
frontend_chk.sv
frontend_tb.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - files:
      - frontend_pkg.sv
      - fetch_req_ctrl.sv
      - bus_tracker.sv
      - prefetch_fifo.sv
      - instr_assembler.sv
      - frontend_top.sv
  - target: test
    files:
      - frontend_chk.sv
      - frontend_tb.sv

// ==== frontend_tb.sv ====
`timescale 1ns/1ps
/*
 * testbench for the instruction-fetch front end:
 * hashed instruction memory with an error window, in-order bus model
 * with random rdy and latency, reference decoder, consumer and jump
 * stimulus, compare tasks and a watchdog
 */

module frontend_tb import frontend_pkg::*; ();

	localparam addr_t reset_vector = 32'h100;
	localparam addr_t err_lo = 32'h400;
	localparam addr_t err_hi = 32'h410;
	localparam int n_tests = 6;
	localparam int cycles_per_test = 300;

	typedef struct packed {
		logic [31:0] instr;
		logic [1:0] len;
		logic [1:0] err;
	} ref_t;

	logic clk;
	logic rst_n;
	addr_t mem_addr;
	logic mem_addr_vld;
	logic mem_addr_rdy;
	fetch_word_u mem_data;
	logic mem_data_err;
	logic mem_data_vld;
	addr_t jump_target;
	logic jump_target_vld;
	logic jump_target_rdy;
	logic [31:0] cir;
	logic [1:0] cir_vld;
	logic [1:0] cir_err;
	logic [1:0] cir_use;

	addr_t pc;
	int err_seen;
	int straddle_seen;

	frontend_top #(
		.reset_vector (reset_vector),
		.fifo_depth   (2)
	) dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// memory model and reference
	// ------------------------------

	// hashed halfword, about three in eight open a 32-bit instruction
	function automatic hw_t code_at(addr_t a);
		logic [31:0] h;
		h = a * 32'h9e3779b1;
		h = h ^ (h >> 16);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 13);
		if (h[2:0] < 3'd3) begin
			return {h[31:18], 2'b11};
		end
		return {h[31:18], (h[17:16] == 2'b11) ? 2'b01 : h[17:16]};
	endfunction

	function automatic fetch_word_u mem_word(addr_t addr);
		fetch_word_u w;
		w.hw[0] = code_at({addr[31:2], 2'b00});
		w.hw[1] = code_at({addr[31:2], 2'b10});
		return w;
	endfunction

	function automatic logic err_at(addr_t addr);
		return {addr[31:2], 2'b00} >= err_lo && {addr[31:2], 2'b00} < err_hi;
	endfunction

	// instruction, length in halfwords and per-halfword errors at pc
	function automatic ref_t ref_instr(addr_t pc_in);
		fetch_word_u w;
		fetch_word_u w_next;
		hw_t lo;
		hw_t hi;
		ref_t r;
		w = mem_word(pc_in);
		w_next = mem_word(pc_in + 32'd4);
		lo = pc_in[1] ? w.hw[1] : w.hw[0];
		hi = pc_in[1] ? w_next.hw[0] : w.hw[1];
		if (lo[1:0] == 2'b11) begin
			r.instr = {hi, lo};
			r.len = 2'd2;
			r.err = {err_at(pc_in + 32'd2), err_at(pc_in)};
		end else begin
			r.instr = {16'h0, lo};
			r.len = 2'd1;
			r.err = {1'b0, err_at(pc_in)};
		end
		return r;
	endfunction

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_instr(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_err(input logic [1:0] got, input logic [1:0] exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// ------------------------------
	// bus model
	// ------------------------------

	// accepts addresses with random rdy and answers in order 1 to 3 cycles later
	initial begin : bus_model
		addr_t pend_addr[$];
		int pend_due[$];
		addr_t exp_addr;
		addr_t held_addr;
		logic hold_prev;
		int cyc;
		int last_due;
		int due;
		mem_addr_rdy = 1'b0;
		mem_data = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		cyc = 0;
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				pend_addr.delete();
				pend_due.delete();
				exp_addr = reset_vector;
				hold_prev = 1'b0;
				last_due = -1;
				mem_data_vld <= 1'b0;
			end else begin
				// a taken jump restarts the address sequence at the word of the target
				if (jump_target_vld && jump_target_rdy) begin
					exp_addr = {jump_target[addr_w-1:2], 2'b00};
				end
				if (hold_prev) begin
					check_flag(mem_addr_vld, 1'b1, "mem_addr_vld");
					check_addr(mem_addr, held_addr, "mem_addr");
				end
				// jumps are refused only while an address phase is held
				check_flag(jump_target_rdy, !hold_prev, "jump_target_rdy");
				hold_prev = mem_addr_vld && !mem_addr_rdy;
				held_addr = mem_addr;
				if (mem_addr_vld && mem_addr_rdy) begin
					check_addr(mem_addr, exp_addr, "mem_addr");
					exp_addr = mem_addr + 32'd4;
					due = cyc + int'($urandom % 3);
					if (due <= last_due) begin
						due = last_due + 1;
					end
					last_due = due;
					pend_addr.push_back(mem_addr);
					pend_due.push_back(due);
				end
				if (pend_due.size() > 0 && pend_due[0] == cyc) begin
					mem_data <= mem_word(pend_addr[0]);
					mem_data_err <= err_at(pend_addr[0]);
					mem_data_vld <= 1'b1;
					void'(pend_addr.pop_front());
					void'(pend_due.pop_front());
				end else begin
					mem_data_vld <= 1'b0;
				end
			end
			mem_addr_rdy <= ($urandom % 4) != 0;
			cyc++;
		end
	end

	// ------------------------------
	// consumer and jumps
	// ------------------------------

	// consumption is decided only on cycles with cir_use at zero, where the CIR cannot shrink
	task automatic consume(input int n);
		ref_t r;
		int done;
		done = 0;
		while (done < n) begin
			@(posedge clk);
			r = ref_instr(pc);
			if (cir_use != 2'd0) begin
				cir_use <= 2'd0;
			end else if (cir_vld != 2'd0) begin
				check_instr({16'h0, cir[15:0]}, {16'h0, r.instr[15:0]}, "cir[15:0]");
				if (cir_vld >= r.len && ($urandom % 4) != 0) begin
					check_instr((r.len == 2'd2) ? cir : {16'h0, cir[15:0]}, r.instr, "cir");
					check_err(cir_err, r.err, "cir_err");
					if (r.err != 2'b00) begin
						err_seen++;
					end
					if (r.len == 2'd2 && pc[1]) begin
						straddle_seen++;
					end
					cir_use <= r.len;
					pc = pc + {r.len, 1'b0};
					done++;
				end
			end
		end
	endtask

	task automatic jump_to(input addr_t target);
		@(posedge clk);
		cir_use <= 2'd0;
		jump_target <= target;
		jump_target_vld <= 1'b1;
		do begin
			@(posedge clk);
		end while (!(jump_target_vld && jump_target_rdy));
		jump_target_vld <= 1'b0;
		pc = target;
		// the CIR is empty right after the jump
		@(posedge clk);
		check_err(cir_vld, 2'd0, "cir_vld");
	endtask

	initial begin : watchdog
		repeat (8 * cycles_per_test * n_tests) @(posedge clk);
		abort_run("timeout: the tests did not finish in the allowed number of cycles");
	end

	initial begin : stimulus
		void'($urandom(41056));
		rst_n = 1'b0;
		cir_use = 2'd0;
		jump_target = '0;
		jump_target_vld = 1'b0;
		pc = reset_vector;
		err_seen = 0;
		straddle_seen = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// holdoff cycle, then the reset vector goes out
		@(posedge clk);
		check_flag(mem_addr_vld, 1'b0, "mem_addr_vld");
		@(posedge clk);
		check_flag(mem_addr_vld, 1'b1, "mem_addr_vld");
		check_addr(mem_addr, reset_vector, "mem_addr");
		consume(40);

		// decode stalls until the queue is full and fetch stops
		repeat (60) begin
			@(posedge clk);
			cir_use <= 2'd0;
		end
		check_flag(mem_addr_vld, 1'b0, "mem_addr_vld");
		consume(40);

		jump_to(32'h200);
		consume(30);
		jump_to(32'h2a6);
		consume(30);
		// runs across the error window
		jump_to(32'h3fa);
		consume(30);
		repeat (4) begin
			jump_to(32'h800 + (($urandom % 1024) << 1));
			consume(10);
		end

		@(posedge clk);
		if (err_seen == 0 || straddle_seen == 0) begin
			abort_run("no error-window or word-straddling instruction was consumed");
		end else if (dut.u_chk.fail_cnt != 0) begin
			abort_run("the bound assertions reported at least one failure");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== frontend_chk.sv ====
`timescale 1ns/1ps
/*
 * concurrent assertions for the fetch front end:
 * pending and flush counters of the bus tracker,
 * decode consumption and valid count of the CIR
 */

module frontend_chk (
	input logic       clk,
	input logic       rst_n,
	input logic [1:0] pending_cnt,
	input logic [1:0] flush_cnt,
	input logic [1:0] cir_use,
	input logic [1:0] cir_vld
);

	// number of assertion failures so far, read by the testbench at the end
	int fail_cnt = 0;

	// the stall logic never lets a third fetch go out
	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n) pending_cnt <= 2'd2)
		else begin
			$error("more than two fetches pending");
			fail_cnt++;
		end

	// only fetches that are still in flight can be flushed
	a_flush_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		flush_cnt <= pending_cnt)
		else begin
			$error("flush count %0d above pending count %0d", flush_cnt, pending_cnt);
			fail_cnt++;
		end

	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
		else begin
			$error("decode consumed %0d halfwords with %0d valid", cir_use, cir_vld);
			fail_cnt++;
		end

	// the CIR holds at most one 32-bit instruction
	a_vld_range: assert property (@(posedge clk) disable iff (!rst_n) cir_vld != 2'd3)
		else begin
			$error("cir_vld reached 3");
			fail_cnt++;
		end

endmodule

// one instance watches the tracker counters and the decode side of the assembler
bind frontend_top frontend_chk u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.pending_cnt (u_tracker.pending_cnt),
	.flush_cnt   (u_tracker.flush_cnt),
	.cir_use     (u_asm.cir_use),
	.cir_vld     (u_asm.cir_vld)
);

// ==== frontend_top.sv ====
`timescale 1ns/1ps
/*
 * instruction-fetch front end top level
 * connects the request FSM, the bus tracker, the prefetch queue
 * and the instruction assembler to the fetch bus and decode
 */

module frontend_top import frontend_pkg::*; #(
	parameter addr_t reset_vector = 32'h0,
	parameter int    fifo_depth = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	output addr_t       mem_addr,
	output logic        mem_addr_vld,
	input  logic        mem_addr_rdy,
	input  fetch_word_u mem_data,
	input  logic        mem_data_err,
	input  logic        mem_data_vld,
	input  addr_t       jump_target,
	input  logic        jump_target_vld,
	output logic        jump_target_rdy,
	output logic [31:0] cir,
	output logic [1:0]  cir_vld,
	output logic [1:0]  cir_err,
	input  logic [1:0]  cir_use
);

	logic jump_now;
	logic fetch_stall;
	logic flushing;
	logic [1:0] data_hwvld;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_almost_full;
	logic room;
	logic bus_beat_vld;
	fetch_data_t bus_beat;
	fetch_data_t fifo_head;

	// ------------------------------
	// glue
	// ------------------------------

	assign bus_beat = '{data: mem_data, hwvld: data_hwvld, err: mem_data_err};

	// beats of flushed fetches are dropped on arrival
	assign bus_beat_vld = mem_data_vld && !flushing;

	// a beat that goes straight into the CIR is not written to the queue as well
	assign fifo_push = bus_beat_vld && !(room && fifo_empty);

	fetch_req_ctrl #(
		.reset_vector (reset_vector)
	) u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.fetch_stall     (fetch_stall),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.jump_now        (jump_now)
	);

	bus_tracker u_tracker (
		.clk              (clk),
		.rst_n            (rst_n),
		.addr_issue       (mem_addr_vld),
		.jump_now         (jump_now),
		.jump_target_bit1 (jump_target[1]),
		.mem_addr_rdy     (mem_addr_rdy),
		.mem_data_vld     (mem_data_vld),
		.fifo_full        (fifo_full),
		.fifo_almost_full (fifo_almost_full),
		.fetch_stall      (fetch_stall),
		.flushing         (flushing),
		.data_hwvld       (data_hwvld)
	);

	prefetch_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (fifo_push),
		.push_data   (bus_beat),
		.pop         (fifo_pop),
		.flush       (jump_now),
		.head        (fifo_head),
		.empty       (fifo_empty),
		.full        (fifo_full),
		.almost_full (fifo_almost_full)
	);

	instr_assembler u_asm (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_head    (fifo_head),
		.fifo_empty   (fifo_empty),
		.bus_beat     (bus_beat),
		.bus_beat_vld (bus_beat_vld),
		.flush        (jump_now),
		.cir_use      (cir_use),
		.fifo_pop     (fifo_pop),
		.room         (room),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_err      (cir_err)
	);

endmodule

// ==== instr_assembler.sv ====
`timescale 1ns/1ps
/*
 * instruction assembly: picks the queue head or the bypassed bus beat,
 * aligns away an invalid low halfword, shifts the CIR down by the decode
 * consumption and overlays fresh data behind what is left
 */

module instr_assembler import frontend_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_data_t fifo_head,
	input  logic        fifo_empty,
	input  fetch_data_t bus_beat,
	input  logic        bus_beat_vld,
	input  logic        flush,
	input  logic [1:0]  cir_use,
	output logic        fifo_pop,
	output logic        room,
	output logic [31:0] cir,
	output logic [1:0]  cir_vld,
	output logic [1:0]  cir_err
);

	cir_state_t st;
	cir_state_t st_next;
	fetch_data_t src;
	logic src_vld;
	fetch_word_u aligned;
	logic [3*hw_w-1:0] shifted;
	logic [3*hw_w-1:0] merged;
	logic [2:0] err_shifted;
	logic [2:0] err_merged;
	logic [1:0] level_keep;
	logic [1:0] fill;
	logic [1:0] level_next;

	// ------------------------------
	// source select and alignment
	// ------------------------------

	// the queue holds older data, so the bus is only used when it is empty
	assign src = fifo_empty ? bus_beat : fifo_head;
	assign src_vld = !fifo_empty || bus_beat_vld;

	// after a jump to an odd halfword only the upper half is real
	always_comb begin
		aligned.hw[1] = src.data.hw[1];
		aligned.hw[0] = src.hwvld[0] ? src.data.hw[0] : src.data.hw[1];
	end

	// ------------------------------
	// shift and overlay
	// ------------------------------

	// halfwords past the level are don't care, so reuse hwbuf to fill them
	always_comb begin
		case (cir_use)
			2'd1: shifted = {st.hwbuf, st.hwbuf, st.cir[31:16]};
			2'd2: shifted = {st.hwbuf, st.cir[31:16], st.hwbuf};
			default: shifted = {st.hwbuf, st.cir};
		endcase
	end

	// errors move with their halfwords
	assign err_shifted = {st.err_buf, st.cir_err} >> cir_use;

	assign level_keep = st.level - cir_use;

	// a full word needs two free halfwords, an aligned half needs one
	assign room = level_keep <= (&src.hwvld ? 2'd1 : 2'd2);
	assign fifo_pop = room && !fifo_empty;
	assign fill = (room && src_vld) ? (&src.hwvld ? 2'd2 : 2'd1) : 2'd0;

	always_comb begin
		if (!room) begin
			merged = shifted;
			err_merged = err_shifted;
		end else if (level_keep == 2'd2) begin
			merged = {aligned.hw[0], shifted[2*hw_w-1:0]};
			err_merged = {src.err, err_shifted[1:0]};
		end else if (level_keep == 2'd1) begin
			merged = {aligned.word, shifted[hw_w-1:0]};
			err_merged = {{2{src.err}}, err_shifted[0]};
		end else begin
			merged = {shifted[3*hw_w-1:2*hw_w], aligned.word};
			err_merged = {err_shifted[2], {2{src.err}}};
		end
	end

	// a jump empties the CIR in the cycle after it is taken
	assign level_next = flush ? 2'd0 : level_keep + fill;

	// ------------------------------
	// next state
	// ------------------------------

	always_comb begin
		st_next.cir = merged[2*hw_w-1:0];
		st_next.hwbuf = merged[3*hw_w-1:2*hw_w];
		st_next.cir_err = err_merged[1:0];
		st_next.err_buf = err_merged[2];
		st_next.level = level_next;
		// 2 is reported only for a complete 32-bit instruction
		if (level_next == 2'd0) begin
			st_next.cir_vld = 2'd0;
		end else if (merged[1:0] == 2'b11 && level_next >= 2'd2) begin
			st_next.cir_vld = 2'd2;
		end else begin
			st_next.cir_vld = 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			st <= '0;
		end else begin
			st <= st_next;
		end
	end

	assign cir = st.cir;
	assign cir_vld = st.cir_vld;
	// the upper error bit is shown only when the upper half is part of the instruction
	assign cir_err = st.cir_err & {st.cir_vld == 2'd2, |st.cir_vld};

endmodule

// ==== prefetch_fifo.sv ====
`timescale 1ns/1ps
/*
 * prefetch queue for returned fetch words
 * entries stay packed from index 0 and shift down on pop,
 * each one carrying its halfword valid bits and bus error
 */

module prefetch_fifo import frontend_pkg::*; #(
	parameter int fifo_depth = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        push,
	input  fetch_data_t push_data,
	input  logic        pop,
	input  logic        flush,
	output fetch_data_t head,
	output logic        empty,
	output logic        full,
	output logic        almost_full
);

	fetch_data_t entry [fifo_depth];
	logic [fifo_depth-1:0] vld;
	logic [fifo_depth-1:0] vld_shift;
	logic [fifo_depth-1:0] land;

	// ------------------------------
	// valid bits
	// ------------------------------

	// occupancy after the pop, before the push
	assign vld_shift = pop ? (vld >> 1) : vld;

	// a push lands on the first free slot behind the survivors
	assign land = ~vld_shift & {vld_shift[fifo_depth-2:0], 1'b1};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else if (flush) begin
			// a jump drops everything, and the word pushed with it too
			vld <= '0;
		end else begin
			vld <= vld_shift | (land & {fifo_depth{push}});
		end
	end

	// ------------------------------
	// payload
	// ------------------------------

	for (genvar g = 0; g < fifo_depth; g++) begin : g_entry
		fetch_data_t above;

		if (g < fifo_depth - 1) begin : g_mid
			assign above = entry[g+1];
		end else begin : g_last
			// the top slot has nothing behind it, a pop leaves it stale
			assign above = entry[g];
		end

		always_ff @(posedge clk) begin
			if (push && land[g]) begin
				entry[g] <= push_data;
			end else if (pop) begin
				entry[g] <= above;
			end
		end
	end

	assign head = entry[0];
	assign empty = !vld[0];
	assign full = vld[fifo_depth-1];
	assign almost_full = vld[fifo_depth-2];

endmodule

// ==== bus_tracker.sv ====
`timescale 1ns/1ps
/*
 * bus pipeline tracking: pending fetch count, flush countdown after a jump,
 * the stall decision and the halfword-valid mask of the next data beat
 */

module bus_tracker (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       addr_issue,
	input  logic       jump_now,
	input  logic       jump_target_bit1,
	input  logic       mem_addr_rdy,
	input  logic       mem_data_vld,
	input  logic       fifo_full,
	input  logic       fifo_almost_full,
	output logic       fetch_stall,
	output logic       flushing,
	output logic [1:0] data_hwvld
);

	logic [1:0] pending_cnt;
	logic [1:0] flush_cnt;
	logic addr_accept;
	// a jump to an odd halfword waits here until its address is accepted
	logic aph_odd;
	// the first surviving beat belongs to an odd jump target
	logic data_odd;

	// the address phase completes where the offer meets rdy
	assign addr_accept = addr_issue && mem_addr_rdy;
	assign flushing = |flush_cnt;

	// the registered count keeps rdy out of the address path,
	// which is why a two-entry queue is needed for full throughput
	assign fetch_stall = fifo_full || (fifo_almost_full && |pending_cnt) || pending_cnt > 2'd1;

	assign data_hwvld = {1'b1, !data_odd};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_cnt <= 2'd0;
			flush_cnt <= 2'd0;
		end else begin
			pending_cnt <= pending_cnt + 2'(addr_accept) - 2'(mem_data_vld);
			// everything still in flight at a jump is stale
			if (jump_now) begin
				flush_cnt <= pending_cnt - 2'(mem_data_vld);
			end else if (flushing && mem_data_vld) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// responses are in order, so the target's beat is the first one not flushed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_odd <= 1'b0;
			data_odd <= 1'b0;
		end else begin
			if (jump_now) begin
				aph_odd <= !addr_accept && jump_target_bit1;
				data_odd <= addr_accept && jump_target_bit1;
			end else begin
				// the target's beat may return while the next address is accepted
				if (mem_data_vld && !flushing) begin
					data_odd <= 1'b0;
				end
				if (addr_accept) begin
					aph_odd <= 1'b0;
					if (aph_odd) begin
						data_odd <= 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== fetch_req_ctrl.sv ====
`timescale 1ns/1ps
/*
 * fetch request FSM: fetch address counter, address-phase hold,
 * single-cycle reset holdoff and jump acceptance
 */

module fetch_req_ctrl import frontend_pkg::*; #(
	parameter addr_t reset_vector = 32'h0
) (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t jump_target,
	input  logic  jump_target_vld,
	output logic  jump_target_rdy,
	input  logic  fetch_stall,
	input  logic  mem_addr_rdy,
	output addr_t mem_addr,
	output logic  mem_addr_vld,
	output logic  jump_now
);

	localparam logic [1:0] st_holdoff = 2'd0;
	localparam logic [1:0] st_run = 2'd1;
	localparam logic [1:0] st_hold = 2'd2;

	localparam addr_t word_step = 4;

	logic [1:0] state;
	addr_t fetch_addr;
	addr_t jump_base;
	logic addr_accept;

	// the bus only ever sees word-aligned requests
	assign jump_base = {jump_target[addr_w-1:2], 2'b00};

	// a held address phase must not change, so jumps wait for it to finish
	assign jump_target_rdy = state != st_hold;
	assign jump_now = jump_target_vld && jump_target_rdy;
	assign addr_accept = mem_addr_vld && mem_addr_rdy;

	// ------------------------------
	// address phase
	// ------------------------------

	always_comb begin
		mem_addr = fetch_addr;
		mem_addr_vld = 1'b0;
		case (state)
			st_hold: begin
				// repeat the registered address until the bus takes it
				mem_addr_vld = 1'b1;
			end
			st_run: begin
				mem_addr_vld = !fetch_stall;
				// a jump target goes out in the same cycle it is presented
				if (jump_target_vld) begin
					mem_addr = jump_base;
				end
			end
			default: begin
				// holdoff after reset, nothing is requested yet
				mem_addr_vld = 1'b0;
			end
		endcase
	end

	// ------------------------------
	// state and fetch address
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_holdoff;
			fetch_addr <= reset_vector;
		end else begin
			// an offered address that was not taken must be held next cycle
			state <= (mem_addr_vld && !mem_addr_rdy) ? st_hold : st_run;
			if (jump_now) begin
				// post-increment when the target itself went straight out
				fetch_addr <= jump_base + (addr_accept ? word_step : addr_t'(0));
			end else if (addr_accept) begin
				fetch_addr <= fetch_addr + word_step;
			end
		end
	end

endmodule

// ==== frontend_pkg.sv ====
/*
 * shared definitions for the instruction-fetch front end:
 * address and halfword widths, the fetch-word union,
 * the fetch-data struct that travels through the prefetch queue,
 * and the state word of the instruction assembler
 */

package frontend_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	localparam int addr_w = 32;

	// one bundle is a halfword, the unit that compressed code is aligned to
	localparam int hw_w = 16;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [hw_w-1:0] hw_t;

	// ------------------------------
	// fetch data
	// ------------------------------

	// a bus word, read whole when it lands in the CIR as a 32-bit chunk,
	// or as two halfwords when the low half has to be aligned away
	typedef union packed {
		logic [2*hw_w-1:0] word;
		hw_t [1:0] hw;
	} fetch_word_u;

	// one returned beat, with its valid halfwords and its bus error
	typedef struct packed {
		fetch_word_u data;
		logic [1:0] hwvld;
		logic err;
	} fetch_data_t;

	// the CIR, the halfword behind it and the number of valid halfwords in both
	// err_buf is the bus error of hwbuf
	typedef struct packed {
		logic [31:0] cir;
		logic [1:0] cir_vld;
		logic [1:0] cir_err;
		hw_t hwbuf;
		logic [1:0] level;
		logic err_buf;
	} cir_state_t;

endpackage
